//--- Bender.yml
package:
  name: irq_core

sources:
  - common/irq_core_pkg.sv
  - csr/cs_registers.sv
  - irq/int_controller.sv
  - src/sleep_unit.sv
  - src/irq_core_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/irq_core_properties.sv
      - verif/tb_irq_core.sv

//--- common/irq_core_pkg.sv
package irq_core_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // CSR address and data port
  localparam int unsigned CSR_ADDR_W = 12;
  localparam int unsigned CSR_DATA_W = 32;

  // CLINT lines, one bit each
  localparam int unsigned IRQ_NUM    = 32;
  localparam int unsigned IRQ_ID_W   = 5;

  // Full machine cycle counter
  localparam int unsigned CYCLE_W    = 64;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [CSR_DATA_W-1:0] csr_data_t;
  typedef logic [IRQ_NUM-1:0]    irq_vec_t;
  typedef logic [IRQ_ID_W-1:0]   irq_id_t;
  typedef logic [CYCLE_W-1:0]    cycle_cnt_t;

  ////////////////////////////////////////
  // CSR map
  ////////////////////////////////////////

  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MIE     = 12'h304;
  localparam csr_addr_t CSR_MIP     = 12'h344;
  localparam csr_addr_t CSR_MCYCLE  = 12'hB00;
  localparam csr_addr_t CSR_MCYCLEH = 12'hB80;

  // Global machine interrupt enable in mstatus
  localparam int unsigned MSTATUS_MIE_BIT = 3;

  // Implemented lines
  // Platform 31..16, MEI 11, MTI 7, MSI 3
  localparam irq_vec_t IRQ_MASK = 32'hFFFF_0888;

  // Boot, run and sleep tracking
  typedef enum logic [1:0] {
    WAIT_FETCH = 2'b00,
    RUN        = 2'b01,
    SLEEP      = 2'b10
  } sleep_state_e;

endpackage

//--- csr/cs_registers.sv
`timescale 1ns/1ps

module cs_registers (
  // Clock and reset
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  // Strobe access port
  input  logic                     csr_we_i,
  input  logic                     csr_re_i,
  input  irq_core_pkg::csr_addr_t  csr_addr_i,
  input  irq_core_pkg::csr_data_t  csr_wdata_i,
  output irq_core_pkg::csr_data_t  csr_rdata_o,
  output logic                     csr_illegal_o,

  // Counter enable from sleep unit
  input  logic                     count_en_i,

  // Interrupt controller side
  input  irq_core_pkg::irq_vec_t   mip_i,
  output logic                     m_irq_enable_o,
  output irq_core_pkg::irq_vec_t   mie_o,

  // Cycle count
  output irq_core_pkg::cycle_cnt_t mcycle_o
);

  import irq_core_pkg::*;

  // Architectural state
  logic       mstatus_mie_q;
  irq_vec_t   mie_q;
  cycle_cnt_t mcycle_q;

  // Address decode
  logic sel_mstatus;
  logic sel_mie;
  logic sel_mip;
  logic sel_mcycle;
  logic sel_mcycleh;
  logic addr_known;

  // Access qualification
  logic access;
  logic illegal;
  logic wr_en;

  ////////////////////////////////////////
  // Decode and illegal detection
  ////////////////////////////////////////

  assign sel_mstatus = (csr_addr_i == CSR_MSTATUS);
  assign sel_mie     = (csr_addr_i == CSR_MIE);
  assign sel_mip     = (csr_addr_i == CSR_MIP);
  assign sel_mcycle  = (csr_addr_i == CSR_MCYCLE);
  assign sel_mcycleh = (csr_addr_i == CSR_MCYCLEH);

  assign addr_known = sel_mstatus | sel_mie | sel_mip | sel_mcycle | sel_mcycleh;

  assign access = csr_we_i | csr_re_i;

  // Unknown address, or write to a read-only CSR
  assign illegal = (access & ~addr_known) | (csr_we_i & (sel_mip | sel_mcycleh));

  // Illegal writes are dropped
  assign wr_en = csr_we_i & ~illegal;

  assign csr_illegal_o = illegal;

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  // mstatus keeps MIE only, mie keeps implemented lines only
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mstatus_mie_q <= 1'b0;
      mie_q         <= '0;
    end else begin
      if (wr_en && sel_mstatus) begin
        mstatus_mie_q <= csr_wdata_i[MSTATUS_MIE_BIT];
      end
      if (wr_en && sel_mie) begin
        mie_q <= csr_wdata_i & IRQ_MASK;
      end
    end
  end

  // Cycle counter
  // software write to low word wins over the increment
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mcycle_q <= '0;
    end else if (wr_en && sel_mcycle) begin
      mcycle_q <= {mcycle_q[CYCLE_W-1:CSR_DATA_W], csr_wdata_i};
    end else if (count_en_i) begin
      mcycle_q <= mcycle_q + cycle_cnt_t'(1);
    end
  end

  ////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////

  // Zero unless a read strobe is present
  always_comb begin
    csr_rdata_o = '0;
    if (csr_re_i) begin
      if (sel_mstatus) begin
        csr_rdata_o[MSTATUS_MIE_BIT] = mstatus_mie_q;
      end
      if (sel_mie) begin
        csr_rdata_o = mie_q;
      end
      if (sel_mip) begin
        csr_rdata_o = mip_i;
      end
      if (sel_mcycle) begin
        csr_rdata_o = mcycle_q[CSR_DATA_W-1:0];
      end
      if (sel_mcycleh) begin
        csr_rdata_o = mcycle_q[CYCLE_W-1:CSR_DATA_W];
      end
    end
  end

  // To interrupt controller and pins
  assign m_irq_enable_o = mstatus_mie_q;
  assign mie_o          = mie_q;
  assign mcycle_o       = mcycle_q;

endmodule

//--- irq/int_controller.sv
`timescale 1ns/1ps

module int_controller (
  // Clock and reset
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  // CLINT interrupt lines
  input  irq_core_pkg::irq_vec_t irq_i,

  // From CSR file
  input  logic                   m_irq_enable_i,
  input  irq_core_pkg::irq_vec_t mie_i,

  // Pending view for mip reads
  output irq_core_pkg::irq_vec_t mip_o,

  // Request, wake-up and selected id
  output logic                   irq_req_o,
  output logic                   irq_wu_o,
  output irq_core_pkg::irq_id_t  irq_id_o
);

  import irq_core_pkg::*;

  // Sampled lines
  irq_vec_t mip_q;

  // Lines both pending and enabled
  irq_vec_t irq_pending;

  // Priority result
  irq_id_t  irq_id;

  ////////////////////////////////////////
  // Line sampling
  ////////////////////////////////////////

  // One cycle of latency from the pins
  // unimplemented lines never show up
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & IRQ_MASK;
    end
  end

  assign mip_o = mip_q;

  ////////////////////////////////////////
  // Masking
  ////////////////////////////////////////

  assign irq_pending = mip_q & mie_i;

  // Wake-up does not look at global enable
  assign irq_wu_o = |irq_pending;

  // Request needs mstatus.MIE as well
  assign irq_req_o = irq_wu_o & m_irq_enable_i;

  ////////////////////////////////////////
  // Fixed priority
  ////////////////////////////////////////

  // Lowest priority first, later hits override
  // order is MTI, MSI, MEI, then platform lines 16..31
  always_comb begin
    irq_id = '0;
    if (irq_pending[7]) begin
      irq_id = irq_id_t'(7);
    end
    if (irq_pending[3]) begin
      irq_id = irq_id_t'(3);
    end
    if (irq_pending[11]) begin
      irq_id = irq_id_t'(11);
    end
    // Highest index among platform lines wins
    for (int i = 16; i < IRQ_NUM; i++) begin
      if (irq_pending[i]) begin
        irq_id = irq_id_t'(i);
      end
    end
  end

  assign irq_id_o = irq_id;

endmodule

//--- list.f
common/irq_core_pkg.sv
csr/cs_registers.sv
irq/int_controller.sv
src/sleep_unit.sv
src/irq_core_top.sv
verif/tb_clk_gen.sv
verif/irq_core_properties.sv
verif/tb_irq_core.sv

//--- src/irq_core_top.sv
`timescale 1ns/1ps

module irq_core_top (
  // Clock and reset
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  // CSR access
  input  logic                     csr_we_i,
  input  logic                     csr_re_i,
  input  irq_core_pkg::csr_addr_t  csr_addr_i,
  input  irq_core_pkg::csr_data_t  csr_wdata_i,
  output irq_core_pkg::csr_data_t  csr_rdata_o,
  output logic                     csr_illegal_o,

  // Interrupts
  input  irq_core_pkg::irq_vec_t   irq_i,
  output logic                     irq_req_o,
  output irq_core_pkg::irq_id_t    irq_id_o,

  // Sleep and debug
  input  logic                     wfi_i,
  input  logic                     debug_req_i,

  // Fetch and status
  input  logic                     fetch_enable_i,
  output logic                     fetch_enable_o,
  output logic                     core_sleep_o,
  output irq_core_pkg::cycle_cnt_t mcycle_o
);

  import irq_core_pkg::*;

  // CSR file to interrupt controller
  logic     m_irq_enable;
  irq_vec_t mie;

  // Interrupt controller back to CSR file
  irq_vec_t mip;

  // Wake-up to sleep unit
  logic     irq_wu;

  // Running indication to cycle counter
  logic     count_en;

  ////////////////////////////////////////
  // CSR file
  ////////////////////////////////////////

  cs_registers csr0 (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .csr_we_i       ( csr_we_i       ),
    .csr_re_i       ( csr_re_i       ),
    .csr_addr_i     ( csr_addr_i     ),
    .csr_wdata_i    ( csr_wdata_i    ),
    .csr_rdata_o    ( csr_rdata_o    ),
    .csr_illegal_o  ( csr_illegal_o  ),
    .count_en_i     ( count_en       ),
    .mip_i          ( mip            ),
    .m_irq_enable_o ( m_irq_enable   ),
    .mie_o          ( mie            ),
    .mcycle_o       ( mcycle_o       )
  );

  ////////////////////////////////////////
  // Interrupt controller
  ////////////////////////////////////////

  int_controller irq0 (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .irq_i          ( irq_i          ),
    .m_irq_enable_i ( m_irq_enable   ),
    .mie_i          ( mie            ),
    .mip_o          ( mip            ),
    .irq_req_o      ( irq_req_o      ),
    .irq_wu_o       ( irq_wu         ),
    .irq_id_o       ( irq_id_o       )
  );

  ////////////////////////////////////////
  // Sleep unit
  ////////////////////////////////////////

  sleep_unit slp0 (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .fetch_enable_o ( fetch_enable_o ),
    .wfi_i          ( wfi_i          ),
    .irq_wu_i       ( irq_wu         ),
    .debug_req_i    ( debug_req_i    ),
    .core_sleep_o   ( core_sleep_o   ),
    .count_en_o     ( count_en       )
  );

endmodule

//--- src/sleep_unit.sv
`timescale 1ns/1ps

module sleep_unit (
  // Clock and reset
  input  logic clk_i,
  input  logic rst_n_i,

  // Boot control
  input  logic fetch_enable_i,
  output logic fetch_enable_o,

  // Sleep entry and wake sources
  input  logic wfi_i,
  input  logic irq_wu_i,
  input  logic debug_req_i,

  // Status
  output logic core_sleep_o,
  output logic count_en_o
);

  import irq_core_pkg::*;

  sleep_state_e state_q;
  sleep_state_e state_d;

  logic fetch_enable_q;
  logic core_sleep_q;
  logic wake;

  // Any source that ends or blocks sleep
  assign wake = irq_wu_i | debug_req_i;

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      WAIT_FETCH: begin
        if (fetch_enable_i) begin
          state_d = RUN;
        end
      end
      // WFI is a no-op when a wake source is already there
      RUN: begin
        if (wfi_i && !wake) begin
          state_d = SLEEP;
        end
      end
      SLEEP: begin
        if (wake) begin
          state_d = RUN;
        end
      end
      default: begin
        state_d = WAIT_FETCH;
      end
    endcase
  end

  // State, sticky fetch enable and sleep flag
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q        <= WAIT_FETCH;
      fetch_enable_q <= 1'b0;
      core_sleep_q   <= 1'b0;
    end else begin
      state_q        <= state_d;
      fetch_enable_q <= fetch_enable_q | fetch_enable_i;
      core_sleep_q   <= (state_d == SLEEP);
    end
  end

  assign fetch_enable_o = fetch_enable_q;
  assign core_sleep_o   = core_sleep_q;

  // Counter runs only while awake and booted
  assign count_en_o = (state_q == RUN);

endmodule

//--- verif/irq_core_properties.sv
`timescale 1ns/1ps

module irq_core_properties (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic                  csr_we_i,
  input logic                  csr_re_i,
  input logic                  csr_illegal_i,
  input logic                  irq_req_i,
  input logic                  irq_wu_i,
  input irq_core_pkg::irq_id_t irq_id_i,
  input logic                  core_sleep_i,
  input logic                  fetch_enabled_i
);

  // Failed assertion count
  int unsigned fail_cnt = 0;

  ////////////////////////////////////////
  // Interrupt and sleep relations
  ////////////////////////////////////////

  // A taken request keeps the core awake
  req_blocks_sleep: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    irq_req_i |=> !core_sleep_i
  ) else begin
    $error("core_sleep_o high one cycle after irq_req_o");
    fail_cnt++;
  end

  // Illegal flag only during an access
  illegal_needs_strobe: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    csr_illegal_i |-> (csr_we_i || csr_re_i)
  ) else begin
    $error("csr_illegal_o high without an access strobe");
    fail_cnt++;
  end

  // Idle id when nothing pending and enabled
  id_zero_when_idle: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (!irq_req_i && !irq_wu_i) |-> (irq_id_i == '0)
  ) else begin
    $error("irq_id_o nonzero with no pending interrupt");
    fail_cnt++;
  end

  // No sleep before boot
  sleep_after_boot: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $rose(core_sleep_i) |-> fetch_enabled_i
  ) else begin
    $error("core_sleep_o rose while fetch_enable_o low");
    fail_cnt++;
  end

endmodule

bind irq_core_top irq_core_properties props0 (
  .clk_i           ( clk_i          ),
  .rst_n_i         ( rst_n_i        ),
  .csr_we_i        ( csr_we_i       ),
  .csr_re_i        ( csr_re_i       ),
  .csr_illegal_i   ( csr_illegal_o  ),
  .irq_req_i       ( irq_req_o      ),
  .irq_wu_i        ( irq_wu         ),
  .irq_id_i        ( irq_id_o       ),
  .core_sleep_i    ( core_sleep_o   ),
  .fetch_enabled_i ( fetch_enable_o )
);

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // Free running clock, 100 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #50 clk_o = ~clk_o;
    end
  end

  // Reset held low for the first 10 rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- verif/tb_irq_core.sv
`timescale 1ns/1ps

module tb_irq_core;

  import irq_core_pkg::*;

  logic clk;
  logic rst_n;

  // DUT inputs
  logic       csr_we;
  logic       csr_re;
  csr_addr_t  csr_addr;
  csr_data_t  csr_wdata;
  irq_vec_t   irq;
  logic       wfi;
  logic       debug_req;
  logic       fetch_enable;

  // DUT outputs
  csr_data_t  csr_rdata;
  logic       csr_illegal;
  logic       irq_req;
  irq_id_t    irq_id;
  logic       fetch_enabled;
  logic       core_sleep;
  cycle_cnt_t mcycle;

  // Error counts per kind of check
  int data_errs = 0;
  int id_errs = 0;
  int bit_errs = 0;
  int cycle_errs = 0;
  int timeout_errs = 0;

  // Model of the DUT registers between edges
  logic     ref_mstatus_mie;
  irq_vec_t ref_mie;
  irq_vec_t ref_mip;

  logic [31:0] lcg_state = 32'h05de9753;

  tb_clk_gen clk_gen0 (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  irq_core_top dut0 (
    .clk_i          ( clk           ),
    .rst_n_i        ( rst_n         ),
    .csr_we_i       ( csr_we        ),
    .csr_re_i       ( csr_re        ),
    .csr_addr_i     ( csr_addr      ),
    .csr_wdata_i    ( csr_wdata     ),
    .csr_rdata_o    ( csr_rdata     ),
    .csr_illegal_o  ( csr_illegal   ),
    .irq_i          ( irq           ),
    .irq_req_o      ( irq_req       ),
    .irq_id_o       ( irq_id        ),
    .wfi_i          ( wfi           ),
    .debug_req_i    ( debug_req     ),
    .fetch_enable_i ( fetch_enable  ),
    .fetch_enable_o ( fetch_enabled ),
    .core_sleep_o   ( core_sleep    ),
    .mcycle_o       ( mcycle        )
  );

  ////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic ref_addr_known(csr_addr_t addr);
    return (addr == CSR_MSTATUS) || (addr == CSR_MIE) || (addr == CSR_MIP) ||
           (addr == CSR_MCYCLE) || (addr == CSR_MCYCLEH);
  endfunction

  // Unknown address, or a write to mip or mcycleh
  function automatic logic ref_illegal(logic we, logic re, csr_addr_t addr);
    return ((we || re) && !ref_addr_known(addr)) ||
           (we && ((addr == CSR_MIP) || (addr == CSR_MCYCLEH)));
  endfunction

  // Counter reads are checked where the count is known
  function automatic csr_data_t ref_csr_read(logic re, csr_addr_t addr, logic mie_en,
                                             irq_vec_t mie, irq_vec_t mip);
    csr_data_t rd;
    rd = '0;
    if (re) begin
      if (addr == CSR_MSTATUS) rd[MSTATUS_MIE_BIT] = mie_en;
      else if (addr == CSR_MIE) rd = mie;
      else if (addr == CSR_MIP) rd = mip;
    end
    return rd;
  endfunction

  // Platform lines from 31 down, then MEI, MSI, MTI
  function automatic irq_id_t ref_priority(irq_vec_t pend);
    for (int i = 31; i >= 16; i--) begin
      if (pend[i]) return irq_id_t'(i);
    end
    if (pend[11]) return irq_id_t'(11);
    if (pend[3]) return irq_id_t'(3);
    if (pend[7]) return irq_id_t'(7);
    return '0;
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_csr_data(string name, csr_data_t got, csr_data_t exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      data_errs++;
    end
  endtask

  task automatic check_irq_id(string name, irq_id_t got, irq_id_t exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      id_errs++;
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      bit_errs++;
    end
  endtask

  task automatic check_cycle(string name, cycle_cnt_t got, cycle_cnt_t exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      cycle_errs++;
    end
  endtask

  ////////////////////////////////////////
  // Continuous compare at the falling edge
  ////////////////////////////////////////

  always @(negedge clk) begin : compare_outputs
    irq_vec_t pend;
    if (!rst_n) begin
      // Next edge resets the DUT
      ref_mstatus_mie = 1'b0;
      ref_mie = '0;
      ref_mip = '0;
    end else begin
      pend = ref_mip & ref_mie;
      check_bit("csr_illegal_o", csr_illegal, ref_illegal(csr_we, csr_re, csr_addr));
      if (!(csr_re && ((csr_addr == CSR_MCYCLE) || (csr_addr == CSR_MCYCLEH)))) begin
        check_csr_data("csr_rdata_o", csr_rdata,
                       ref_csr_read(csr_re, csr_addr, ref_mstatus_mie, ref_mie, ref_mip));
      end
      check_bit("irq_req_o", irq_req, (|pend) & ref_mstatus_mie);
      check_irq_id("irq_id_o", irq_id, ref_priority(pend));
      // Register updates taken at the next edge
      if (csr_we && !ref_illegal(csr_we, csr_re, csr_addr)) begin
        if (csr_addr == CSR_MSTATUS) ref_mstatus_mie = csr_wdata[MSTATUS_MIE_BIT];
        if (csr_addr == CSR_MIE) ref_mie = csr_wdata & IRQ_MASK;
      end
      ref_mip = irq & IRQ_MASK;
    end
  end

  ////////////////////////////////////////
  // Drive tasks
  ////////////////////////////////////////

  task automatic csr_write(csr_addr_t addr, csr_data_t data);
    @(posedge clk);
    csr_we    <= 1'b1;
    csr_addr  <= addr;
    csr_wdata <= data;
    @(posedge clk);
    csr_we    <= 1'b0;
  endtask

  task automatic csr_read(csr_addr_t addr);
    @(posedge clk);
    csr_re   <= 1'b1;
    csr_addr <= addr;
    @(posedge clk);
    csr_re   <= 1'b0;
  endtask

  // Read strobe for one cycle with the data checked mid-cycle
  task automatic csr_read_expect(csr_addr_t addr, csr_data_t exp);
    @(posedge clk);
    csr_re   <= 1'b1;
    csr_addr <= addr;
    @(negedge clk);
    check_csr_data("csr_rdata_o", csr_rdata, exp);
    @(posedge clk);
    csr_re   <= 1'b0;
  endtask

  task automatic drive_irq(irq_vec_t v);
    @(posedge clk);
    irq <= v;
  endtask

  task automatic idle(int n);
    repeat (n) @(negedge clk);
  endtask

  // One-cycle WFI pulse and sleep seen after the next edge
  task automatic enter_sleep();
    @(posedge clk);
    wfi <= 1'b1;
    @(posedge clk);
    wfi <= 1'b0;
    @(negedge clk);
    check_bit("core_sleep_o", core_sleep, 1'b1);
  endtask

  task automatic wait_reset_release(int limit);
    int n;
    n = 0;
    while ((rst_n !== 1'b1) && (n < limit)) begin
      @(negedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset was not released after %0d cycles", limit);
      timeout_errs++;
    end
  endtask

  task automatic wait_fetch_enabled(int limit);
    int n;
    n = 0;
    while ((fetch_enabled !== 1'b1) && (n < limit)) begin
      @(negedge clk);
      n++;
    end
    if (fetch_enabled !== 1'b1) begin
      $display("Timeout: fetch_enable_o did not rise within %0d cycles", limit);
      timeout_errs++;
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin : stimulus
    cycle_cnt_t base;
    logic [31:0] r;
    csr_addr_t   a;
    irq_vec_t    v;
    csr_we       <= 1'b0;
    csr_re       <= 1'b0;
    csr_addr     <= '0;
    csr_wdata    <= '0;
    irq          <= '0;
    wfi          <= 1'b0;
    debug_req    <= 1'b0;
    fetch_enable <= 1'b0;
    wait_reset_release(50);
    @(negedge clk);

    // Values right after reset
    check_bit("irq_req_o", irq_req, 1'b0);
    check_bit("core_sleep_o", core_sleep, 1'b0);
    check_bit("fetch_enable_o", fetch_enabled, 1'b0);
    check_bit("csr_illegal_o", csr_illegal, 1'b0);
    check_cycle("mcycle_o", mcycle, '0);

    // Random writes and reads and the mip view
    for (int i = 0; i < 16; i++) begin
      csr_write(CSR_MIE, next_rand());
      csr_read(CSR_MIE);
      csr_write(CSR_MSTATUS, next_rand());
      csr_read(CSR_MSTATUS);
      drive_irq(next_rand());
      csr_read(CSR_MIP);
    end
    drive_irq('0);

    // Illegal accesses change nothing
    for (int i = 0; i < 12; i++) begin
      r = next_rand();
      a = r[11:0];
      if (ref_addr_known(a)) a = a ^ 12'h001;
      csr_write(a, next_rand());
      csr_read(a);
    end
    csr_write(CSR_MIP, '1);
    csr_write(CSR_MCYCLEH, '1);
    csr_read(CSR_MIE);
    csr_read(CSR_MSTATUS);
    @(negedge clk);
    check_cycle("mcycle_o", mcycle, '0);

    // Low word load with no counting before boot
    csr_write(CSR_MCYCLE, 32'hFFFF_FFFA);
    idle(4);
    check_cycle("mcycle_o", mcycle, 64'h0000_0000_FFFF_FFFA);
    csr_read_expect(CSR_MCYCLE, 32'hFFFF_FFFA);
    csr_read_expect(CSR_MCYCLEH, 32'h0000_0000);

    // Boot and carry into the high word
    @(posedge clk);
    fetch_enable <= 1'b1;
    wait_fetch_enabled(20);
    check_cycle("mcycle_o", mcycle, 64'h0000_0000_FFFF_FFFA);
    idle(10);
    check_cycle("mcycle_o", mcycle, 64'h0000_0001_0000_0004);
    csr_read_expect(CSR_MCYCLEH, 32'h0000_0001);
    @(posedge clk);
    fetch_enable <= 1'b0;
    idle(2);
    check_bit("fetch_enable_o", fetch_enabled, 1'b1);

    // Priority with MIE set
    csr_write(CSR_MSTATUS, 32'h0000_0008);
    for (int i = 0; i < 24; i++) begin
      csr_write(CSR_MIE, next_rand() | (i[0] ? 32'h0000_0888 : 32'h0));
      for (int j = 0; j < 4; j++) begin
        v = next_rand() & next_rand() & next_rand();
        if (j[0]) v = v & 32'h0000_FFFF;
        drive_irq(v);
      end
    end
    csr_write(CSR_MIE, IRQ_MASK);
    drive_irq(32'h0000_0888);
    drive_irq(32'h0000_0088);
    drive_irq(32'h0000_0080);
    drive_irq(32'h8001_0888);
    drive_irq(32'h0000_0444);
    drive_irq('0);

    // Sleep with frozen counter and debug wake
    csr_write(CSR_MSTATUS, 32'h0);
    csr_write(CSR_MIE, 32'h0000_0800);
    @(negedge clk);
    check_bit("core_sleep_o", core_sleep, 1'b0);
    enter_sleep();
    base = mcycle;
    for (int k = 0; k < 6; k++) begin
      @(negedge clk);
      check_bit("core_sleep_o", core_sleep, 1'b1);
    end
    check_cycle("mcycle_o", mcycle, base);
    @(posedge clk);
    debug_req <= 1'b1;
    @(posedge clk);
    debug_req <= 1'b0;
    @(negedge clk);
    check_bit("core_sleep_o", core_sleep, 1'b0);
    check_cycle("mcycle_o", mcycle, base);
    idle(3);
    check_cycle("mcycle_o", mcycle, base + 64'd3);

    // WFI with debug already present is a no-op
    @(posedge clk);
    wfi       <= 1'b1;
    debug_req <= 1'b1;
    @(posedge clk);
    wfi       <= 1'b0;
    debug_req <= 1'b0;
    @(negedge clk);
    check_bit("core_sleep_o", core_sleep, 1'b0);

    // Enabled line wakes even with MIE clear
    enter_sleep();
    drive_irq(32'h0000_0800);
    @(negedge clk);
    check_bit("core_sleep_o", core_sleep, 1'b1);
    @(negedge clk);
    check_bit("core_sleep_o", core_sleep, 1'b1);
    @(negedge clk);
    check_bit("core_sleep_o", core_sleep, 1'b0);
    drive_irq('0);
    idle(2);

    // Line pending but masked until mie opens it
    csr_write(CSR_MSTATUS, 32'h0000_0008);
    enter_sleep();
    drive_irq(32'h8000_0000);
    idle(3);
    check_bit("core_sleep_o", core_sleep, 1'b1);
    csr_write(CSR_MIE, 32'h8000_0800);
    @(negedge clk);
    check_bit("core_sleep_o", core_sleep, 1'b1);
    @(negedge clk);
    check_bit("core_sleep_o", core_sleep, 1'b0);
    drive_irq('0);
    csr_write(CSR_MIE, 32'h0);
    idle(4);

    $display("Errors: csr_data=%0d irq_id=%0d bit=%0d cycle=%0d timeout=%0d assert=%0d",
             data_errs, id_errs, bit_errs, cycle_errs, timeout_errs,
             dut0.props0.fail_cnt);
    if ((data_errs + id_errs + bit_errs + cycle_errs + timeout_errs +
         dut0.props0.fail_cnt) == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
